// ==== all.f ====
+incdir+verification
hw/lockPkg.sv
hw/keyEntry.sv
hw/lockChecker.sv
hw/digitScanner.sv
hw/comboLock.sv
verification/comboLockTb.sv

// ==== hw/comboLock.sv ====
`timescale 1ns/1ps

module comboLock
	import lockPkg::*;
#(
	parameter int scanDivBits = SCAN_DIV_BITS
)
(
	input  logic        CLK,
	input  logic        rst,
	input  logic        keyValid,
	input  keyCodeE     keyCode,
	input  logic [11:0] secret,
	output logic [7:0]  segOut,
	output logic [3:0]  digitSel
);

	keyEntryT   entry;
	lockStatusT status;
	logic       submit;
	logic       clearEntry;

	keyEntry u_keyEntry
	(
		.CLK        (CLK),
		.rst        (rst),
		.keyValid   (keyValid),
		.keyCode    (keyCode),
		.clearEntry (clearEntry),
		.entry      (entry),
		.submit     (submit)
	);

	lockChecker u_lockChecker
	(
		.CLK        (CLK),
		.rst        (rst),
		.entry      (entry),
		.submit     (submit),
		.secret     (secret),
		.status     (status),
		.clearEntry (clearEntry)
	);

	digitScanner #(
		.scanDivBits (scanDivBits)
	) u_digitScanner
	(
		.CLK      (CLK),
		.rst      (rst),
		.entry    (entry),
		.status   (status),
		.segOut   (segOut),
		.digitSel (digitSel)
	);

endmodule

// ==== hw/digitScanner.sv ====
`timescale 1ns/1ps

module digitScanner
	import lockPkg::*;
#(
	parameter int scanDivBits = SCAN_DIV_BITS
)
(
	input  logic       CLK,
	input  logic       rst,
	input  keyEntryT   entry,
	input  lockStatusT status,
	output logic [7:0] segOut,
	output logic [3:0] digitSel
);

	logic [scanDivBits+1:0] divCnt;
	logic [1:0]             pos;
	glyphE                  glyph;
	logic [3:0]             selD;
	logic [7:0]             segQ;
	logic [3:0]             selQ;

	always_ff @(posedge CLK)
	begin
		if (rst)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	assign pos = divCnt[scanDivBits+1 -: 2]; // top two bits

	// active-low select, position 0 rightmost
	always_comb
	begin
		case (pos)
			2'd0:
				selD = 4'b1110;
			2'd1:
				selD = 4'b1101;
			2'd2:
				selD = 4'b1011;
			default:
				selD = 4'b0111;
		endcase
	end

	// glyph for current position
	always_comb
	begin
		glyph = glyBlank;
		case (status.state)
			stOpen:
			begin
				case (pos)
					2'd3:
						glyph = glyP;
					2'd2:
						glyph = glyA;
					default:
						glyph = glyS;
				endcase
			end
			stLocked:
				glyph = glyDash;
			default:
			begin
				if (pos == 2'd3)
					glyph = glyphE'({1'b0, status.tries});
				else if (pos < entry.count)
					glyph = glyphE'(entry.digits[4*pos +: 4]);
				else
					glyph = glyBlank; // not typed yet
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			selQ <= 4'b1110;
			segQ <= '0;
		end
		else
		begin
			selQ <= selD;
			segQ <= SEG_TABLE[glyph];
		end
	end

	assign digitSel = selQ;
	assign segOut   = segQ;

	selOneHot: assert property (@(posedge CLK) disable iff (rst)
		$onehot(~digitSel))
		else $error("digitSel not one-hot low");

endmodule

// ==== hw/keyEntry.sv ====
`timescale 1ns/1ps

module keyEntry
	import lockPkg::*;
(
	input  logic     CLK,
	input  logic     rst,
	input  logic     keyValid,
	input  keyCodeE  keyCode,
	input  logic     clearEntry,
	output keyEntryT entry,
	output logic     submit
);

	keyEntryT entryQ;
	logic     submitQ;

	logic     isDigit;
	logic     doShift;
	logic     doClear;
	logic     doSubmit;
	logic     entryFull;

	assign isDigit   = (keyCode <= key9);
	assign entryFull = (entryQ.count >= 2'(NUM_DIGITS));

	// key decode
	always_comb
	begin
		doShift  = 1'b0;
		doClear  = 1'b0;
		doSubmit = 1'b0;
		if (keyValid)
		begin
			if (isDigit)
				doShift = !entryFull; // fourth digit dropped
			else
			begin
				case (keyCode)
					keyEnter:
						doSubmit = !submitQ;
					keyClear:
						doClear = 1'b1;
					keyLock:
					begin
						// empty submit, read as relock downstream
						doClear  = 1'b1;
						doSubmit = !submitQ;
					end
					default:
						; // unused codes
				endcase
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			entryQ  <= '0;
			submitQ <= 1'b0;
		end
		else
		begin
			submitQ <= doSubmit;
			if (doClear || clearEntry)
				entryQ <= '0;
			else if (doShift)
			begin
				entryQ.digits <= {entryQ.digits[4*NUM_DIGITS-5:0], 4'(keyCode)};
				entryQ.count  <= entryQ.count + 2'd1;
			end
		end
	end

	assign entry  = entryQ;
	assign submit = submitQ;

	// lockChecker takes one submit per compare
	submitSingle: assert property (@(posedge CLK) disable iff (rst)
		submit |=> !submit)
		else $error("submit high two cycles in a row");

endmodule

// ==== hw/lockChecker.sv ====
`timescale 1ns/1ps

module lockChecker
	import lockPkg::*;
(
	input  logic        CLK,
	input  logic        rst,
	input  keyEntryT    entry,
	input  logic        submit,
	input  logic [11:0] secret,
	output lockStatusT  status,
	output logic        clearEntry
);

	lockStatusT statusQ;
	lockStatusT statusD;
	logic       clearQ;
	logic       clearD;

	logic       codeMatch;
	logic       entryEmpty;
	logic       lastTry;

	assign codeMatch  = (entry.digits == secret);
	assign entryEmpty = (entry.count == 2'd0);
	assign lastTry    = (statusQ.tries == 3'(MAX_TRIES - 1));

	// next state
	always_comb
	begin
		statusD = statusQ;
		clearD  = 1'b0;
		if (submit)
		begin
			case (statusQ.state)
				stIdle:
				begin
					// an empty entry is not a try
					if (!entryEmpty)
					begin
						clearD = 1'b1;
						if (codeMatch)
							statusD.state = stOpen;
						else if (lastTry)
						begin
							statusD.tries = 3'(MAX_TRIES);
							statusD.state = stLocked;
						end
						else
							statusD.tries = statusQ.tries + 3'd1;
					end
				end
				stOpen:
				begin
					if (entryEmpty) // keyLock
					begin
						statusD.state = stIdle;
						statusD.tries = 3'd0;
						clearD        = 1'b1;
					end
				end
				stLocked:
					; // held until rst
				default:
				begin
					statusD.state = stIdle;
					statusD.tries = 3'd0;
				end
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			statusQ.state <= stIdle;
			statusQ.tries <= 3'd0;
			clearQ        <= 1'b0;
		end
		else
		begin
			statusQ <= statusD;
			clearQ  <= clearD;
		end
	end

	assign status     = statusQ;
	assign clearEntry = clearQ;

	triesInRange: assert property (@(posedge CLK) disable iff (rst)
		statusQ.tries <= 3'(MAX_TRIES))
		else $error("tries above MAX_TRIES");

	lockoutHeld: assert property (@(posedge CLK) disable iff (rst)
		statusQ.state == stLocked |=> statusQ.state == stLocked)
		else $error("left lockout without reset");

endmodule

// ==== hw/lockPkg.sv ====
package lockPkg;

	localparam int NUM_DIGITS    = 3;
	localparam int MAX_TRIES     = 6;
	localparam int SCAN_DIV_BITS = 16; // 2^16 cycles per digit

	typedef enum logic [3:0]
	{
		key0     = 4'h0,
		key1     = 4'h1,
		key2     = 4'h2,
		key3     = 4'h3,
		key4     = 4'h4,
		key5     = 4'h5,
		key6     = 4'h6,
		key7     = 4'h7,
		key8     = 4'h8,
		key9     = 4'h9,
		keyEnter = 4'hA,
		keyClear = 4'hB,
		keyLock  = 4'hC
	} keyCodeE;

	typedef enum logic [1:0]
	{
		stIdle   = 2'd0,
		stOpen   = 2'd1,
		stLocked = 2'd2
	} lockStateE;

	typedef struct packed
	{
		logic [11:0] digits; // digit 0 in low nibble
		logic [1:0]  count;
	} keyEntryT;

	typedef struct packed
	{
		lockStateE  state;
		logic [2:0] tries;
	} lockStatusT;

	typedef enum logic [3:0]
	{
		gly0     = 4'h0,
		gly1     = 4'h1,
		gly2     = 4'h2,
		gly3     = 4'h3,
		gly4     = 4'h4,
		gly5     = 4'h5,
		gly6     = 4'h6,
		gly7     = 4'h7,
		gly8     = 4'h8,
		gly9     = 4'h9,
		glyP     = 4'hA,
		glyA     = 4'hB,
		glyS     = 4'hC,
		glyDash  = 4'hD,
		glyBlank = 4'hE
	} glyphE;

	// segments gfedcba, active high
	localparam logic [7:0] SEG_TABLE [0:15] = '{
		8'h3f, 8'h06, 8'h5b, 8'h4f,
		8'h66, 8'h6d, 8'h7d, 8'h07,
		8'h7f, 8'h6f,
		8'h73, // P
		8'h77, // A
		8'h6d, // S
		8'h40, // dash
		8'h00, // blank
		8'h00
	};

endpackage

// ==== verification/comboLockChecks.svh ====
`ifndef COMBO_LOCK_CHECKS_SVH
`define COMBO_LOCK_CHECKS_SVH

task automatic checkSegs(input int pos, input glyphE expGlyph, input logic [7:0] gotSeg);
	checkCount++;
	if (gotSeg !== SEG_TABLE[expGlyph])
	begin
		errorCount++;
		testErrors++;
		$display("Error at %0t: position %0d shows %h, expected %h (%s)",
			$time, pos, gotSeg, SEG_TABLE[expGlyph], expGlyph.name());
	end
endtask

// position 3 carries the lock state
task automatic checkState(input lockStatusT expStatus, input logic [7:0] gotSeg);
	glyphE expGlyph;
	case (expStatus.state)
		stOpen:
			expGlyph = glyP;
		stLocked:
			expGlyph = glyDash;
		default:
			expGlyph = glyphE'({1'b0, expStatus.tries});
	endcase
	checkCount++;
	if (gotSeg !== SEG_TABLE[expGlyph])
	begin
		errorCount++;
		testErrors++;
		$display("Error at %0t: state %s tries %0d expects %h at position 3, got %h",
			$time, expStatus.state.name(), expStatus.tries, SEG_TABLE[expGlyph], gotSeg);
	end
endtask

// select rotates 1110, 1101, 1011, 0111, four cycles each with scanDivBits 2
task automatic compareSelStep(input logic [3:0] prevSel, input logic [3:0] gotSel,
	input int held, input logic fullRun);
	checkCount++;
	if (gotSel !== {prevSel[2:0], prevSel[3]} || (fullRun && held != 4))
	begin
		errorCount++;
		testErrors++;
		$display("Error at %0t: digitSel stepped %b to %b after %0d cycles",
			$time, prevSel, gotSel, held);
	end
endtask

// one full scan is 16 cycles with scanDivBits 2
task automatic captureDisplay();
	logic [3:0] seen;
	logic [3:0] prevSel;
	int         cyc;
	int         held;
	int         steps;
	seen    = 4'b0000;
	prevSel = digitSel;
	cyc     = 0;
	held    = 1;
	steps   = 0;
	while (seen != 4'b1111 && cyc < 20)
	begin
		@(negedge CLK);
		if (digitSel !== prevSel)
		begin
			compareSelStep(prevSel, digitSel, held, steps > 0);
			prevSel = digitSel;
			held    = 1;
			steps++;
		end
		else
			held++; // first run may be partial
		case (digitSel)
			4'b1110:
			begin
				capSeg[0] = segOut;
				seen[0]   = 1'b1;
			end
			4'b1101:
			begin
				capSeg[1] = segOut;
				seen[1]   = 1'b1;
			end
			4'b1011:
			begin
				capSeg[2] = segOut;
				seen[2]   = 1'b1;
			end
			4'b0111:
			begin
				capSeg[3] = segOut;
				seen[3]   = 1'b1;
			end
			default:
				;
		endcase
		cyc++;
	end
	if (seen != 4'b1111)
	begin
		errorCount++;
		testErrors++;
		$display("The display scan did not reach every digit position in time");
	end
endtask

`endif

// ==== verification/comboLockTb.sv ====
`timescale 1ns/1ps

module comboLockTb
	import lockPkg::*;
();

	localparam int NUM_ROWS    = 18;
	localparam int NUM_RAND    = 8;
	localparam int MAX_KEYS    = 8;
	localparam int WATCHDOG_NS = (NUM_ROWS + NUM_RAND + 1) * (MAX_KEYS + 4 * 4 + 10) * 20;

	typedef struct packed
	{
		logic        preReset;
		logic [31:0] keys; // first key in the highest used nibble
		logic [3:0]  numKeys;
		logic [11:0] secret;
		lockStateE   state;
		logic [2:0]  tries;
		glyphE       g3;
		glyphE       g2;
		glyphE       g1;
		glyphE       g0;
	} rowT;

	logic        CLK;
	logic        rst;
	logic        keyValid;
	keyCodeE     keyCode;
	logic [11:0] secret;
	logic [7:0]  segOut;
	logic [3:0]  digitSel;

	logic [7:0]  capSeg [0:3];
	rowT         rows [0:NUM_ROWS-1];
	int          errorCount;
	int          checkCount;
	int          testErrors;
	int          testCount;
	integer      seed;

	comboLock #(
		.scanDivBits (2)
	) u_comboLock
	(
		.CLK      (CLK),
		.rst      (rst),
		.keyValid (keyValid),
		.keyCode  (keyCode),
		.secret   (secret),
		.segOut   (segOut),
		.digitSel (digitSel)
	);

	`include "comboLockChecks.svh"

	function automatic rowT makeRow(input logic preReset, input logic [31:0] keys,
		input int numKeys, input logic [11:0] code, input lockStateE state, input int tries,
		input glyphE g3, input glyphE g2, input glyphE g1, input glyphE g0);
		rowT r;
		r.preReset = preReset;
		r.keys     = keys;
		r.numKeys  = 4'(numKeys);
		r.secret   = code;
		r.state    = state;
		r.tries    = 3'(tries);
		r.g3       = g3;
		r.g2       = g2;
		r.g1       = g1;
		r.g0       = g0;
		return r;
	endfunction

	task automatic pulseReset();
		@(negedge CLK);
		rst = 1'b1;
		repeat (2) @(negedge CLK);
		rst = 1'b0;
	endtask

	task automatic applyKeys(input logic [31:0] keys, input int numKeys);
		int i;
		for (i = 0; i < numKeys; i++)
		begin
			@(negedge CLK);
			keyValid = 1'b1;
			keyCode  = keyCodeE'(keys[4*(numKeys-1-i) +: 4]);
		end
		@(negedge CLK);
		keyValid = 1'b0;
		keyCode  = key0;
		repeat (4) @(negedge CLK); // status +2, entry clear +3, display +4
	endtask

	task automatic checkDisplay(input lockStatusT expStatus,
		input glyphE g3, input glyphE g2, input glyphE g1, input glyphE g0);
		testErrors = 0;
		captureDisplay();
		checkState(expStatus, capSeg[3]);
		checkSegs(3, g3, capSeg[3]);
		checkSegs(2, g2, capSeg[2]);
		checkSegs(1, g1, capSeg[1]);
		checkSegs(0, g0, capSeg[0]);
		if (testErrors == 0)
			$display("test %0d: ok", testCount);
		else
			$display("test %0d: %0d mismatches", testCount, testErrors);
		testCount++;
	endtask

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		lockStatusT exp;
		logic [3:0]  d2, d1, d0;
		logic [11:0] code;
		int          r;
		int          k;
		rst        = 1'b1;
		keyValid   = 1'b0;
		keyCode    = key0;
		secret     = 12'h123;
		errorCount = 0;
		checkCount = 0;
		testErrors = 0;
		testCount  = 0;
		seed       = 32'h6b13;

		rows[0]  = makeRow(0, 32'h0, 0, 12'h123, stIdle, 0, gly0, glyBlank, glyBlank, glyBlank);
		rows[1]  = makeRow(0, 32'h45, 2, 12'h123, stIdle, 0, gly0, glyBlank, gly4, gly5);
		rows[2]  = makeRow(0, 32'h67, 2, 12'h123, stIdle, 0, gly0, gly4, gly5, gly6);
		rows[3]  = makeRow(0, 32'hB, 1, 12'h123, stIdle, 0, gly0, glyBlank, glyBlank, glyBlank);
		rows[4]  = makeRow(0, 32'hA, 1, 12'h123, stIdle, 0, gly0, glyBlank, glyBlank, glyBlank);
		rows[5]  = makeRow(0, 32'h123A, 4, 12'h123, stOpen, 0, glyP, glyA, glyS, glyS);
		rows[6]  = makeRow(0, 32'hC, 1, 12'h123, stIdle, 0, gly0, glyBlank, glyBlank, glyBlank);
		rows[7]  = makeRow(0, 32'h999A, 4, 12'h123, stIdle, 1, gly1, glyBlank, glyBlank, glyBlank);
		rows[8]  = makeRow(0, 32'h12A, 3, 12'h123, stIdle, 2, gly2, glyBlank, glyBlank, glyBlank);
		rows[9]  = makeRow(0, 32'h888A, 4, 12'h123, stIdle, 3, gly3, glyBlank, glyBlank, glyBlank);
		rows[10] = makeRow(0, 32'h777A, 4, 12'h123, stIdle, 4, gly4, glyBlank, glyBlank, glyBlank);
		rows[11] = makeRow(0, 32'h000A, 4, 12'h123, stIdle, 5, gly5, glyBlank, glyBlank, glyBlank);
		rows[12] = makeRow(0, 32'h321A, 4, 12'h123, stLocked, 6, glyDash, glyDash, glyDash, glyDash);
		rows[13] = makeRow(0, 32'h123A, 4, 12'h123, stLocked, 6, glyDash, glyDash, glyDash, glyDash);
		rows[14] = makeRow(0, 32'hC, 1, 12'h123, stLocked, 6, glyDash, glyDash, glyDash, glyDash);
		rows[15] = makeRow(1, 32'h0, 0, 12'h123, stIdle, 0, gly0, glyBlank, glyBlank, glyBlank);
		rows[16] = makeRow(0, 32'h907A, 4, 12'h907, stOpen, 0, glyP, glyA, glyS, glyS);
		rows[17] = makeRow(0, 32'hC, 1, 12'h907, stIdle, 0, gly0, glyBlank, glyBlank, glyBlank);

		repeat (2) @(negedge CLK);
		rst = 1'b0;

		for (r = 0; r < NUM_ROWS; r++)
		begin
			if (rows[r].preReset)
				pulseReset();
			@(negedge CLK);
			secret = rows[r].secret;
			applyKeys(rows[r].keys, int'(rows[r].numKeys));
			exp.state = rows[r].state;
			exp.tries = rows[r].tries;
			checkDisplay(exp, rows[r].g3, rows[r].g2, rows[r].g1, rows[r].g0);
		end

		// random wrong codes from a fresh reset
		pulseReset();
		secret = 12'h123;
		for (k = 1; k <= NUM_RAND; k++)
		begin
			code = secret;
			while (code == secret)
			begin
				d2   = 4'({$random(seed)} % 10);
				d1   = 4'({$random(seed)} % 10);
				d0   = 4'({$random(seed)} % 10);
				code = {d2, d1, d0};
			end
			applyKeys({16'h0, code, 4'hA}, 4);
			exp.tries = 3'((k < MAX_TRIES) ? k : MAX_TRIES);
			exp.state = (k < MAX_TRIES) ? stIdle : stLocked;
			if (exp.state == stLocked)
				checkDisplay(exp, glyDash, glyDash, glyDash, glyDash);
			else
				checkDisplay(exp, glyphE'({1'b0, exp.tries}), glyBlank, glyBlank, glyBlank);
		end

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
